// ==== design/commu_macros.svh ====
// sizing constants for the frame buffer subsystem, included by the package and by the RTL
`ifndef COMMU_MACROS_SVH
`define COMMU_MACROS_SVH

// ------------------------------
// bank memory
// ------------------------------

// number of frame banks
`define COMMU_BANKS 8

// byte address width inside one bank
`define COMMU_BANK_AW 10

// ------------------------------
// frame timing
// ------------------------------

// cycles from frame end to the write bank switch
`define COMMU_SWITCH_DLY 8

// idle cycles between frames, must exceed the switch delay
`define COMMU_FRAME_GAP 12

`endif

// ==== design/commu_pkg.sv ====
// shared types for the frame buffer subsystem, referenced by scoped names from the RTL
`include "commu_macros.svh"

package commu_pkg;

	// ------------------------------
	// data widths
	// ------------------------------

	// source or trailer word
	typedef logic [15:0] word_t;

	// one buffered byte
	typedef logic [7:0] byte_t;

	// byte address inside a bank
	typedef logic [`COMMU_BANK_AW-1:0] baddr_t;

	// bank index
	typedef logic [2:0] bank_t;

	// frame length in bytes, one bit wider than an address
	typedef logic [`COMMU_BANK_AW:0] blen_t;

	// ------------------------------
	// state machines
	// ------------------------------

	typedef enum logic [2:0] {
		REPK_IDLE,
		REPK_DATA,
		REPK_TRAILER,
		REPK_TAIL,
		REPK_GAP
	} repack_state_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_READ,
		RD_CLOSE,
		RD_GAP
	} reader_state_e;

endpackage

// ==== design/commu_bank_ram.sv ====
// one byte-wide dual-port frame bank, instantiated once per bank inside the buffer
`timescale 1ns/1ps
`include "commu_macros.svh"

module commu_bank_ram (
	input  logic             clk_sys,
	input  commu_pkg::byte_t  data,
	input  commu_pkg::baddr_t wraddress,
	input  commu_pkg::baddr_t rdaddress,
	input  logic             wren,
	output commu_pkg::byte_t  q
);

	localparam int DEPTH = 2 ** `COMMU_BANK_AW;

	commu_pkg::byte_t mem [DEPTH];

	// write port
	always_ff @(posedge clk_sys) begin
		if (wren) begin
			mem[wraddress] <= data;
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge clk_sys) begin
		q <= mem[rdaddress];
	end

endmodule

// ==== design/commu_repack.sv ====
// frames source words for the buffer and closes each frame with a 16-bit sum trailer
`timescale 1ns/1ps
`include "commu_macros.svh"

module commu_repack (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  commu_pkg::word_t word_data,
	input  logic            word_vld,
	input  logic            word_last,
	output commu_pkg::word_t repk_data,
	output logic            repk_vld,
	output logic            repk_frm,
	output logic            src_busy
);

	localparam int GAP_W = $clog2(`COMMU_FRAME_GAP);

	commu_pkg::repack_state_e state;
	logic [GAP_W-1:0]         cnt;
	commu_pkg::word_t         sum;

	logic accept;
	logic trl_stb;

	// ------------------------------
	// strobe decode
	// ------------------------------

	// words are taken only before the trailer
	assign accept = word_vld &&
		(state == commu_pkg::REPK_IDLE || state == commu_pkg::REPK_DATA);

	// second cycle of TRAILER carries the sum
	assign trl_stb = (state == commu_pkg::REPK_TRAILER) && (cnt != '0);

	assign repk_vld  = accept || trl_stb;
	assign repk_data = trl_stb ? sum : word_data;

	// frame opens together with the first word
	assign repk_frm = (state == commu_pkg::REPK_DATA) ||
		(state == commu_pkg::REPK_TRAILER) ||
		(state == commu_pkg::REPK_TAIL) ||
		(state == commu_pkg::REPK_IDLE && word_vld);

	assign src_busy = (state == commu_pkg::REPK_TRAILER) ||
		(state == commu_pkg::REPK_TAIL) ||
		(state == commu_pkg::REPK_GAP);

	// ------------------------------
	// FSM
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= commu_pkg::REPK_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				commu_pkg::REPK_IDLE: begin
					if (word_vld) begin
						cnt   <= '0;
						state <= word_last ? commu_pkg::REPK_TRAILER : commu_pkg::REPK_DATA;
					end
				end
				commu_pkg::REPK_DATA: begin
					if (word_vld && word_last) begin
						cnt   <= '0;
						state <= commu_pkg::REPK_TRAILER;
					end
				end
				commu_pkg::REPK_TRAILER: begin
					// one wait cycle, then the sum strobe
					if (cnt == '0) begin
						cnt <= GAP_W'(1);
					end else begin
						state <= commu_pkg::REPK_TAIL;
					end
				end
				commu_pkg::REPK_TAIL: begin
					// trailer low byte goes in here
					cnt   <= GAP_W'(`COMMU_FRAME_GAP - 1);
					state <= commu_pkg::REPK_GAP;
				end
				commu_pkg::REPK_GAP: begin
					if (cnt == '0) begin
						state <= commu_pkg::REPK_IDLE;
					end else begin
						cnt <= cnt - GAP_W'(1);
					end
				end
				default: begin
					state <= commu_pkg::REPK_IDLE;
				end
			endcase
		end
	end

	// running sum, restarted by the first word
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			sum <= (state == commu_pkg::REPK_IDLE) ? word_data : sum + word_data;
		end
	end

	// buffer splits each word over two cycles
	a_word_spacing: assert property (@(posedge clk_sys) disable iff (!rst_n)
		word_vld |=> !word_vld);

endmodule

// ==== design/commu_m_buf.sv ====
// eight-bank frame buffer, bytes written high first and read out bank by bank on request
`timescale 1ns/1ps
`include "commu_macros.svh"

module commu_m_buf (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  commu_pkg::word_t repk_data,
	input  logic            repk_vld,
	input  logic            repk_frm,
	input  logic            buf_rd,
	input  logic            buf_frm,
	output commu_pkg::byte_t buf_q
);

	logic                          repk_frm_reg;
	logic                          repk_frm_fall;
	logic [`COMMU_SWITCH_DLY-1:0]  fall_dly;
	commu_pkg::bank_t              wr_bank;

	logic                          repk_vld_reg;
	commu_pkg::byte_t              lo_byte;
	commu_pkg::byte_t              wdata;
	logic                          wren;
	commu_pkg::baddr_t             waddr;

	logic                          buf_frm_reg;
	logic                          buf_frm_fall;
	commu_pkg::bank_t              rd_bank;
	commu_pkg::baddr_t             raddr;
	commu_pkg::byte_t              bank_q [`COMMU_BANKS];

	// ------------------------------
	// write bank switch
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			repk_frm_reg <= 1'b0;
			fall_dly     <= '0;
			wr_bank      <= '0;
		end else begin
			repk_frm_reg <= repk_frm;
			fall_dly     <= {fall_dly[`COMMU_SWITCH_DLY-2:0], repk_frm_fall};
			if (fall_dly[`COMMU_SWITCH_DLY-1]) begin
				wr_bank <= wr_bank + 3'd1;
			end
		end
	end

	assign repk_frm_fall = repk_frm_reg && !repk_frm;

	// ------------------------------
	// write path
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			repk_vld_reg <= 1'b0;
		end else begin
			repk_vld_reg <= repk_vld;
		end
	end

	// low byte held for the second write cycle
	always_ff @(posedge clk_sys) begin
		if (repk_vld) begin
			lo_byte <= repk_data[7:0];
		end
	end

	assign wren  = repk_vld || repk_vld_reg;
	assign wdata = repk_vld ? repk_data[15:8] : lo_byte;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			waddr <= '0;
		end else if (wren) begin
			waddr <= waddr + 1'b1;
		end else if (!repk_frm) begin
			waddr <= '0;
		end
	end

	// ------------------------------
	// read path
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			raddr       <= '0;
			buf_frm_reg <= 1'b0;
			rd_bank     <= '0;
		end else begin
			buf_frm_reg <= buf_frm;
			if (buf_rd) begin
				raddr <= raddr + 1'b1;
			end else if (!buf_frm) begin
				raddr <= '0;
			end
			// oldest bank done, move on
			if (buf_frm_fall) begin
				rd_bank <= rd_bank + 3'd1;
			end
		end
	end

	assign buf_frm_fall = buf_frm_reg && !buf_frm;
	assign buf_q        = bank_q[rd_bank];

	// ------------------------------
	// banks
	// ------------------------------

	for (genvar i = 0; i < `COMMU_BANKS; i++) begin : g_bank
		commu_bank_ram bank_inst (
			.clk_sys   (clk_sys),
			.data      (wdata),
			.wraddress (waddr),
			.rdaddress (raddr),
			.wren      (wren && (wr_bank == 3'(i))),
			.q         (bank_q[i])
		);
	end

	// each word needs two write cycles
	a_vld_spacing: assert property (@(posedge clk_sys) disable iff (!rst_n)
		repk_vld |=> !repk_vld);

	// frame must fit in one bank
	a_no_wrap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(wren && repk_frm) |=> (waddr != '0));

endmodule

// ==== design/commu_frame_reader.sv ====
// reads one buffered frame per request, forwards its bytes and checks the sum trailer
`timescale 1ns/1ps

module commu_frame_reader (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  logic            rd_start,
	input  commu_pkg::blen_t rd_len,
	input  commu_pkg::byte_t buf_q,
	output logic            buf_rd,
	output logic            buf_frm,
	output logic            rd_busy,
	output commu_pkg::byte_t out_byte,
	output logic            out_vld,
	output logic            out_last,
	output logic            out_sum_ok
);

	commu_pkg::reader_state_e state;
	commu_pkg::blen_t         rem;
	logic                     gap_cnt;
	logic                     start_acc;

	logic                     odd;
	commu_pkg::byte_t         hi_byte;
	commu_pkg::word_t         sum;

	assign start_acc = rd_start && (state == commu_pkg::RD_IDLE);

	assign buf_rd  = (state == commu_pkg::RD_READ);
	assign buf_frm = (state == commu_pkg::RD_READ) || (state == commu_pkg::RD_CLOSE);
	assign rd_busy = (state != commu_pkg::RD_IDLE);

	// ------------------------------
	// FSM
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= commu_pkg::RD_IDLE;
			rem      <= '0;
			gap_cnt  <= 1'b0;
			out_vld  <= 1'b0;
			out_last <= 1'b0;
		end else begin
			// bank data comes back one cycle after each read
			out_vld  <= (state == commu_pkg::RD_READ);
			out_last <= (state == commu_pkg::RD_READ) && (rem == 1);
			case (state)
				commu_pkg::RD_IDLE: begin
					if (rd_start) begin
						rem   <= rd_len;
						state <= commu_pkg::RD_READ;
					end
				end
				commu_pkg::RD_READ: begin
					rem <= rem - 1'b1;
					if (rem == 1) begin
						state <= commu_pkg::RD_CLOSE;
					end
				end
				commu_pkg::RD_CLOSE: begin
					gap_cnt <= 1'b0;
					state   <= commu_pkg::RD_GAP;
				end
				commu_pkg::RD_GAP: begin
					gap_cnt <= 1'b1;
					if (gap_cnt) begin
						state <= commu_pkg::RD_IDLE;
					end
				end
				default: begin
					state <= commu_pkg::RD_IDLE;
				end
			endcase
		end
	end

	// ------------------------------
	// trailer check
	// ------------------------------

	// high byte of each pair comes first
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			odd <= 1'b0;
		end else if (start_acc) begin
			odd <= 1'b0;
		end else if (out_vld) begin
			odd <= !odd;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_acc) begin
			sum <= '0;
		end else if (out_vld && odd && !out_last) begin
			sum <= sum + {hi_byte, buf_q};
		end
		if (out_vld && !odd) begin
			hi_byte <= buf_q;
		end
	end

	assign out_byte = buf_q;

	// last pair is the trailer itself
	assign out_sum_ok = out_last && ({hi_byte, buf_q} == sum);

	a_len_ok: assert property (@(posedge clk_sys) disable iff (!rst_n)
		start_acc |-> (!rd_len[0] && rd_len >= 4));

endmodule

// ==== design/commu_top.sv ====
// top level of the master-side frame buffer, connects repacker, buffer and reader
`timescale 1ns/1ps

module commu_top (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  commu_pkg::word_t word_data,
	input  logic            word_vld,
	input  logic            word_last,
	input  logic            rd_start,
	input  commu_pkg::blen_t rd_len,
	output logic            src_busy,
	output logic            rd_busy,
	output commu_pkg::byte_t out_byte,
	output logic            out_vld,
	output logic            out_last,
	output logic            out_sum_ok
);

	// repacker to buffer
	commu_pkg::word_t repk_data;
	logic             repk_vld;
	logic             repk_frm;

	// reader to buffer
	logic             buf_rd;
	logic             buf_frm;
	commu_pkg::byte_t buf_q;

	commu_repack repack_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.word_data (word_data),
		.word_vld  (word_vld),
		.word_last (word_last),
		.repk_data (repk_data),
		.repk_vld  (repk_vld),
		.repk_frm  (repk_frm),
		.src_busy  (src_busy)
	);

	commu_m_buf m_buf_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.repk_data (repk_data),
		.repk_vld  (repk_vld),
		.repk_frm  (repk_frm),
		.buf_rd    (buf_rd),
		.buf_frm   (buf_frm),
		.buf_q     (buf_q)
	);

	commu_frame_reader frame_reader_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rd_start   (rd_start),
		.rd_len     (rd_len),
		.buf_q      (buf_q),
		.buf_rd     (buf_rd),
		.buf_frm    (buf_frm),
		.rd_busy    (rd_busy),
		.out_byte   (out_byte),
		.out_vld    (out_vld),
		.out_last   (out_last),
		.out_sum_ok (out_sum_ok)
	);

endmodule

// ==== dv/tb_commu.sv ====
// self-checking testbench for the frame buffer top level, run as the simulation top
`timescale 1ns/1ps

module tb_commu;

	localparam int NUM_FRAMES = 23;
	localparam int ROT_LAST   = 20;

	typedef commu_pkg::byte_t byte_q_t[$];
	typedef commu_pkg::word_t word_q_t[$];

	logic             clk_sys;
	logic             rst_n;
	commu_pkg::word_t word_data;
	logic             word_vld;
	logic             word_last;
	logic             rd_start;
	commu_pkg::blen_t rd_len;
	logic             src_busy;
	logic             rd_busy;
	commu_pkg::byte_t out_byte;
	logic             out_vld;
	logic             out_last;
	logic             out_sum_ok;

	// frame store and expected output kept in write order
	word_q_t all_words;
	int      frame_wcnt [NUM_FRAMES];
	int      frame_base [NUM_FRAMES];
	byte_q_t exp_q;
	int      len_q [$];
	int      start_q [$];
	int      total_bytes;
	bit      gen_done;
	int      cyc;
	int      byte_idx;
	int      written;
	int      read_done;

	commu_top commu_top_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.word_data  (word_data),
		.word_vld   (word_vld),
		.word_last  (word_last),
		.rd_start   (rd_start),
		.rd_len     (rd_len),
		.src_busy   (src_busy),
		.rd_busy    (rd_busy),
		.out_byte   (out_byte),
		.out_vld    (out_vld),
		.out_last   (out_last),
		.out_sum_ok (out_sum_ok)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
	end

	// ------------------------------
	// reference model and checks
	// ------------------------------

	// each word high byte first and the 16-bit sum trailer last
	function automatic byte_q_t frame_bytes(input word_q_t words);
		byte_q_t          bytes;
		commu_pkg::word_t sum;
		sum = '0;
		foreach (words[i]) begin
			bytes.push_back(words[i][15:8]);
			bytes.push_back(words[i][7:0]);
			sum = sum + words[i];
		end
		bytes.push_back(sum[15:8]);
		bytes.push_back(sum[7:0]);
		return bytes;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input commu_pkg::byte_t exp,
			input commu_pkg::byte_t act);
		if (act !== exp) begin
			report_failure($sformatf("ERROR at %0t ns: %s expected 0x%02h, got 0x%02h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("ERROR at %0t ns: %s expected %b, got %b",
				$time, name, exp, act));
		end
	endtask

	task automatic check_cycle(input int exp, input int act);
		if (act != exp) begin
			report_failure($sformatf("ERROR at %0t ns: out_vld cycle expected %0d, got %0d",
				$time, exp, act));
		end
	endtask

	task automatic build_frames();
		int unsigned r;
		word_q_t     words;
		byte_q_t     bytes;
		for (int k = 0; k < NUM_FRAMES; k++) begin
			if (k == 0) begin
				frame_wcnt[k] = 5;
			end else if (k <= ROT_LAST) begin
				frame_wcnt[k] = $urandom_range(1, 60);
			end else begin
				frame_wcnt[k] = k - 18;
			end
			frame_base[k] = all_words.size();
			words.delete();
			for (int i = 0; i < frame_wcnt[k]; i++) begin
				r = $urandom();
				words.push_back(commu_pkg::word_t'(r));
				all_words.push_back(commu_pkg::word_t'(r));
			end
			bytes = frame_bytes(words);
			foreach (bytes[i]) begin
				exp_q.push_back(bytes[i]);
			end
			len_q.push_back(bytes.size());
			total_bytes += bytes.size();
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	// inject adds stray strobes while the repacker is busy
	task automatic write_frame(input int k, input bit inject);
		int          idle;
		int          pulses;
		bit          busy;
		int unsigned r;
		for (int i = 0; i < frame_wcnt[k]; i++) begin
			@(posedge clk_sys);
			#0.5;
			word_vld  = 1'b1;
			word_data = all_words[frame_base[k] + i];
			word_last = (i == frame_wcnt[k] - 1);
			@(posedge clk_sys);
			#0.5;
			word_vld  = 1'b0;
			word_last = 1'b0;
			idle = $urandom_range(0, 2);
			repeat (idle) @(posedge clk_sys);
		end
		busy   = 1'b1;
		pulses = 0;
		while (busy) begin
			@(posedge clk_sys);
			#0.5;
			busy = src_busy;
			if (busy && inject && pulses < 4 && !word_vld) begin
				r = $urandom();
				word_vld  = 1'b1;
				word_data = commu_pkg::word_t'(r);
				word_last = r[16];
				pulses++;
			end else begin
				word_vld  = 1'b0;
				word_last = 1'b0;
			end
		end
		written++;
	endtask

	// dup repeats rd_start while the reader is still busy
	task automatic read_frame(input int k, input bit dup);
		do begin
			@(posedge clk_sys);
			#0.5;
		end while (rd_busy);
		rd_start = 1'b1;
		rd_len   = commu_pkg::blen_t'(2 * frame_wcnt[k] + 2);
		start_q.push_back(cyc);
		@(posedge clk_sys);
		#0.5;
		rd_start = 1'b0;
		if (dup) begin
			repeat (2) @(posedge clk_sys);
			#0.5;
			check_flag("rd_busy", 1'b1, rd_busy);
			rd_start = 1'b1;
			rd_len   = commu_pkg::blen_t'(4);
			@(posedge clk_sys);
			#0.5;
			rd_start = 1'b0;
		end
	endtask

	// at most seven frames unread
	task automatic run_writes();
		for (int k = 1; k <= ROT_LAST; k++) begin
			while (written - read_done >= 7) @(posedge clk_sys);
			write_frame(k, 1'b0);
		end
	endtask

	// reads lag a few frames so they overlap newer writes
	task automatic run_reads();
		int need;
		for (int k = 1; k <= ROT_LAST; k++) begin
			need = (k + 3 < ROT_LAST + 1) ? k + 3 : ROT_LAST + 1;
			while (written < need) @(posedge clk_sys);
			read_frame(k, 1'b0);
		end
	endtask

	// ------------------------------
	// output compare
	// ------------------------------

	always @(negedge clk_sys) begin : compare_out
		bit last_byte;
		if (rst_n) begin
			if (out_vld) begin
				if (exp_q.size() == 0 || start_q.size() == 0) begin
					report_failure("out_vld was raised with no read outstanding");
				end else begin
					last_byte = (byte_idx == len_q[0] - 1);
					check_cycle(start_q[0] + 2 + byte_idx, cyc);
					check_byte("out_byte", exp_q.pop_front(), out_byte);
					check_flag("out_last", last_byte, out_last);
					check_flag("out_sum_ok", last_byte, out_sum_ok);
					if (last_byte) begin
						void'(len_q.pop_front());
						void'(start_q.pop_front());
						byte_idx = 0;
						read_done++;
					end else begin
						byte_idx++;
					end
				end
			end else begin
				check_flag("out_last", 1'b0, out_last);
				check_flag("out_sum_ok", 1'b0, out_sum_ok);
			end
		end
	end

	initial begin : watchdog
		while (!gen_done) @(posedge clk_sys);
		repeat (64 * total_bytes + 1000) @(posedge clk_sys);
		report_failure($sformatf("TIMEOUT: the run did not finish within %0d cycles",
			64 * total_bytes + 1000));
	end

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		word_data = '0;
		word_vld  = 1'b0;
		word_last = 1'b0;
		rd_start  = 1'b0;
		rd_len    = '0;
		void'($urandom(32'h74e7_fcc1));
		build_frames();
		gen_done = 1'b1;
		repeat (2) @(posedge clk_sys);
		#0.5;
		rst_n = 1'b1;

		// idle outputs after reset
		@(negedge clk_sys);
		check_flag("src_busy", 1'b0, src_busy);
		check_flag("rd_busy", 1'b0, rd_busy);
		check_flag("out_vld", 1'b0, out_vld);
		check_flag("out_last", 1'b0, out_last);
		check_flag("out_sum_ok", 1'b0, out_sum_ok);

		// single 5-word round trip
		write_frame(0, 1'b0);
		read_frame(0, 1'b0);
		while (read_done < 1) @(posedge clk_sys);

		// bank rotation with overlapped writes and reads
		fork
			run_writes();
			run_reads();
		join

		// stray strobes and a second rd_start while busy
		write_frame(ROT_LAST + 1, 1'b1);
		write_frame(ROT_LAST + 2, 1'b0);
		read_frame(ROT_LAST + 1, 1'b1);
		read_frame(ROT_LAST + 2, 1'b0);
		while (read_done < NUM_FRAMES) @(posedge clk_sys);
		repeat (20) @(posedge clk_sys);

		// both sides back to idle
		@(negedge clk_sys);
		check_flag("src_busy", 1'b0, src_busy);
		check_flag("rd_busy", 1'b0, rd_busy);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+design
design/commu_pkg.sv
design/commu_bank_ram.sv
design/commu_repack.sv
design/commu_m_buf.sv
design/commu_frame_reader.sv
design/commu_top.sv
dv/tb_commu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_commu -f sim.f -o tb_commu

out=$(./obj_dir/tb_commu 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
